// ==== src/lc3b_pkg.sv ====
`default_nettype none

package lc3b_pkg;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;
    typedef logic [2:0]  lc3b_nzp;

    // opcode values keep their LC-3b encodings in bits 15:12
    typedef enum logic [3:0]
    {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    // alu_none must stay at zero so that a cleared control word is a bubble
    typedef enum logic [2:0]
    {
        alu_none  = 3'd0,
        alu_add   = 3'd1,
        alu_and   = 3'd2,
        alu_not   = 3'd3,
        alu_lshf  = 3'd4,
        alu_rshfl = 3'd5,
        alu_rshfa = 3'd6,
        alu_pass  = 3'd7
    } lc3b_aluop;

    typedef struct packed
    {
        lc3b_opcode opcode;
        lc3b_aluop  aluop;
        logic       use_imm;
        logic       reg_write;
        logic       set_cc;
        logic       branch;
        logic       jump;
        logic       link;
        lc3b_nzp    nzp;
        logic       valid;
    } lc3b_control_word;

    typedef struct packed
    {
        lc3b_word         pc;
        lc3b_reg          dest;
        lc3b_reg          src1;
        lc3b_reg          src2;
        lc3b_word         sr1;
        lc3b_word         sr2;
        lc3b_word         imm5;
        lc3b_word         imm4;
        lc3b_word         offset9;
        lc3b_word         offset11;
        lc3b_control_word ctrl;
    } lc3b_decoded;

endpackage

`default_nettype wire

// ==== src/lc3b_fetch.sv ====
`timescale 1ns/10ps
`default_nettype none

module lc3b_fetch
    import lc3b_pkg::*;
#(
    parameter lc3b_word RESET_PC = 16'h0000
)
(
    input  logic     clk,
    input  logic     reset,
    output logic     wb_cyc,
    output logic     wb_stb,
    output logic     wb_we,
    output lc3b_word wb_adr,
    input  lc3b_word wb_dat_i,
    input  logic     wb_ack,
    input  logic     redirect,
    input  lc3b_word redirect_pc,
    output logic     if_valid,
    output lc3b_word if_instr,
    output lc3b_word if_pc
);

    typedef enum logic
    {
        fetch_idle,
        fetch_requesting
    } fetch_state_t;

    fetch_state_t state;
    lc3b_word     pc;
    lc3b_word     discard_pc;
    logic         discard;
    logic         keep_ack;

    assign wb_cyc = (state == fetch_requesting);
    assign wb_stb = (state == fetch_requesting);
    assign wb_we  = 1'b0;
    assign wb_adr = {pc[15:1], 1'b0};

    // an ack is thrown away if it answers a request made before a redirect
    assign keep_ack = wb_ack && wb_stb && !discard && !redirect;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state    <= fetch_idle;
            pc       <= RESET_PC;
            discard  <= 1'b0;
            if_valid <= 1'b0;
        end
        else
        begin
            state    <= fetch_requesting;
            if_valid <= keep_ack;
            if (redirect && wb_stb && !wb_ack)
            begin
                // the address must hold until the pending cycle is acked
                discard <= 1'b1;
            end
            else if (redirect)
            begin
                discard <= 1'b0;
                pc      <= redirect_pc;
            end
            else if (wb_ack && wb_stb && discard)
            begin
                discard <= 1'b0;
                pc      <= discard_pc;
            end
            else if (keep_ack)
            begin
                pc <= pc + 16'd2;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (redirect)
            discard_pc <= redirect_pc;
        if (keep_ack)
        begin
            if_instr <= wb_dat_i;
            if_pc    <= pc + 16'd2;
        end
    end

    a_adr_stable: assert property (@(posedge clk) disable iff (reset)
        (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr)));

endmodule

`default_nettype wire

// ==== src/lc3b_regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

module lc3b_regfile
    import lc3b_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     we,
    input  lc3b_reg  wdest,
    input  lc3b_word wdata,
    input  lc3b_reg  rsrc1,
    input  lc3b_reg  rsrc2,
    output lc3b_word rdata1,
    output lc3b_word rdata2
);

    lc3b_word regs [8];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 8; i++)
                regs[i] <= '0;
        end
        else if (we)
        begin
            regs[wdest] <= wdata;
        end
    end

    // write-through so decode sees the result retiring in the same cycle
    assign rdata1 = (we && wdest == rsrc1) ? wdata : regs[rsrc1];
    assign rdata2 = (we && wdest == rsrc2) ? wdata : regs[rsrc2];

endmodule

`default_nettype wire

// ==== src/lc3b_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module lc3b_decode
    import lc3b_pkg::*;
(
    input  logic        if_valid,
    input  lc3b_word    if_instr,
    input  lc3b_word    if_pc,
    output lc3b_reg     rsrc1,
    output lc3b_reg     rsrc2,
    input  lc3b_word    rdata1,
    input  lc3b_word    rdata2,
    output logic        advance,
    output lc3b_decoded decoded
);

    lc3b_opcode       opcode;
    lc3b_control_word ctrl;

    assign opcode  = lc3b_opcode'(if_instr[15:12]);
    assign advance = if_valid;

    // base register for JMP and JSRR also sits in bits 8:6
    assign rsrc1 = if_instr[8:6];
    assign rsrc2 = if_instr[2:0];

    always_comb
    begin
        ctrl        = '0;
        ctrl.opcode = opcode;
        ctrl.valid  = if_valid;
        case (opcode)
            op_add, op_and:
            begin
                ctrl.aluop     = (opcode == op_add) ? alu_add : alu_and;
                ctrl.use_imm   = if_instr[5];
                ctrl.reg_write = 1'b1;
                ctrl.set_cc    = 1'b1;
            end
            op_not:
            begin
                ctrl.aluop     = alu_not;
                ctrl.reg_write = 1'b1;
                ctrl.set_cc    = 1'b1;
            end
            op_shf:
            begin
                if (!if_instr[4])
                    ctrl.aluop = alu_lshf;
                else if (!if_instr[5])
                    ctrl.aluop = alu_rshfl;
                else
                    ctrl.aluop = alu_rshfa;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.set_cc    = 1'b1;
            end
            op_lea:
            begin
                // LC-3b leaves the condition codes alone on LEA
                ctrl.aluop     = alu_pass;
                ctrl.reg_write = 1'b1;
            end
            op_br:
            begin
                ctrl.branch = 1'b1;
                ctrl.nzp    = if_instr[11:9];
            end
            op_jmp:
                ctrl.jump = 1'b1;
            op_jsr:
            begin
                // bit 11 picks the PC-relative form over the base register
                ctrl.jump      = 1'b1;
                ctrl.link      = 1'b1;
                ctrl.use_imm   = if_instr[11];
                ctrl.reg_write = 1'b1;
            end
            default:
                ctrl.aluop = alu_none;
        endcase
    end

    always_comb
    begin
        decoded.pc       = if_pc;
        decoded.dest     = ctrl.link ? 3'd7 : if_instr[11:9];
        decoded.src1     = rsrc1;
        decoded.src2     = rsrc2;
        decoded.sr1      = rdata1;
        decoded.sr2      = rdata2;
        decoded.imm5     = {{11{if_instr[4]}}, if_instr[4:0]};
        // the shift amount is unsigned
        decoded.imm4     = {12'd0, if_instr[3:0]};
        decoded.offset9  = {{7{if_instr[8]}}, if_instr[8:0]};
        decoded.offset11 = {{5{if_instr[10]}}, if_instr[10:0]};
        decoded.ctrl     = ctrl;
    end

endmodule

`default_nettype wire

// ==== src/lc3b_id_ex.sv ====
`timescale 1ns/10ps
`default_nettype none

module lc3b_id_ex
    import lc3b_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        advance,
    input  logic        flush,
    input  lc3b_decoded decoded_in,
    output lc3b_decoded decoded_out
);

    logic load;

    // decode never stalls, so a held entry would execute a second time
    assign load = advance && !flush;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            decoded_out <= '0;
        end
        else if (load)
        begin
            decoded_out <= decoded_in;
        end
        else
        begin
            decoded_out <= '0;
        end
    end

    // decode marks as valid exactly the instructions that it passes on
    a_advance_valid: assert property (@(posedge clk) disable iff (reset)
        advance == decoded_in.ctrl.valid);

    // every valid entry was fetched from an even address
    a_pc_even: assert property (@(posedge clk) disable iff (reset)
        decoded_out.ctrl.valid |-> !decoded_out.pc[0]);

endmodule

`default_nettype wire

// ==== src/lc3b_execute.sv ====
`timescale 1ns/10ps
`default_nettype none

module lc3b_execute
    import lc3b_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  lc3b_decoded ex,
    output logic        redirect,
    output lc3b_word    redirect_pc,
    output logic        rf_we,
    output lc3b_reg     rf_dest,
    output lc3b_word    rf_wdata,
    output logic        ret_valid,
    output lc3b_word    ret_pc,
    output logic        ret_we,
    output lc3b_reg     ret_dest,
    output lc3b_word    ret_value,
    output lc3b_nzp     ret_nzp
);

    lc3b_nzp  nzp;
    lc3b_nzp  result_nzp;
    lc3b_word operand_b;
    lc3b_word alu_result;
    lc3b_word br_target;
    lc3b_word jsr_target;
    logic [3:0] shamt;

    assign operand_b  = ex.ctrl.use_imm ? ex.imm5 : ex.sr2;
    assign shamt      = ex.imm4[3:0];
    assign br_target  = ex.pc + {ex.offset9[14:0], 1'b0};
    assign jsr_target = ex.pc + {ex.offset11[14:0], 1'b0};

    always_comb
    begin
        case (ex.ctrl.aluop)
            alu_add:   alu_result = ex.sr1 + operand_b;
            alu_and:   alu_result = ex.sr1 & operand_b;
            alu_not:   alu_result = ~ex.sr1;
            alu_lshf:  alu_result = ex.sr1 << shamt;
            alu_rshfl: alu_result = ex.sr1 >> shamt;
            alu_rshfa: alu_result = lc3b_word'($signed(ex.sr1) >>> shamt);
            alu_pass:  alu_result = br_target;
            default:   alu_result = ex.sr1;
        endcase
    end

    // R7 gets the address of the instruction after the JSR
    assign rf_wdata = ex.ctrl.link ? ex.pc : alu_result;
    assign rf_dest  = ex.dest;
    assign rf_we    = ex.ctrl.valid && ex.ctrl.reg_write;

    assign result_nzp = rf_wdata[15] ? 3'b100 : (rf_wdata == '0) ? 3'b010 : 3'b001;

    assign redirect = ex.ctrl.valid &&
                      ((ex.ctrl.branch && |(ex.ctrl.nzp & nzp)) || ex.ctrl.jump);

    always_comb
    begin
        if (ex.ctrl.branch)
            redirect_pc = br_target;
        else if (ex.ctrl.use_imm)
            redirect_pc = jsr_target;
        else
            redirect_pc = ex.sr1;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            nzp       <= 3'b010;
            ret_valid <= 1'b0;
        end
        else
        begin
            ret_valid <= ex.ctrl.valid;
            if (ex.ctrl.valid && ex.ctrl.set_cc)
                nzp <= result_nzp;
        end
    end

    always_ff @(posedge clk)
    begin
        ret_pc    <= ex.pc - 16'd2;
        ret_we    <= rf_we;
        ret_dest  <= rf_dest;
        ret_value <= rf_wdata;
        ret_nzp   <= (ex.ctrl.valid && ex.ctrl.set_cc) ? result_nzp : nzp;
    end

    // the flush in ID/EX guarantees a redirect never repeats on the next cycle
    a_redirect_pulse: assert property (@(posedge clk) disable iff (reset)
        redirect |=> !redirect);

endmodule

`default_nettype wire

// ==== src/lc3b_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module lc3b_core
    import lc3b_pkg::*;
#(
    parameter lc3b_word RESET_PC = 16'h0000
)
(
    input  logic     clk,
    input  logic     reset,
    output logic     wb_cyc,
    output logic     wb_stb,
    output logic     wb_we,
    output lc3b_word wb_adr,
    input  lc3b_word wb_dat_i,
    input  logic     wb_ack,
    output logic     ret_valid,
    output lc3b_word ret_pc,
    output logic     ret_we,
    output lc3b_reg  ret_dest,
    output lc3b_word ret_value,
    output lc3b_nzp  ret_nzp
);

    logic        redirect;
    lc3b_word    redirect_pc;
    logic        if_valid;
    lc3b_word    if_instr;
    lc3b_word    if_pc;
    lc3b_reg     rsrc1;
    lc3b_reg     rsrc2;
    lc3b_word    rdata1;
    lc3b_word    rdata2;
    logic        advance;
    lc3b_decoded decoded;
    lc3b_decoded ex;
    logic        rf_we;
    lc3b_reg     rf_dest;
    lc3b_word    rf_wdata;

    lc3b_fetch #(.RESET_PC(RESET_PC)) fetch_i (
        .clk, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_i, .wb_ack,
        .redirect, .redirect_pc, .if_valid, .if_instr, .if_pc
    );

    lc3b_regfile regfile_i (
        .clk, .reset, .we(rf_we), .wdest(rf_dest), .wdata(rf_wdata),
        .rsrc1, .rsrc2, .rdata1, .rdata2
    );

    lc3b_decode decode_i (
        .if_valid, .if_instr, .if_pc, .rsrc1, .rsrc2, .rdata1, .rdata2,
        .advance, .decoded
    );

    lc3b_id_ex id_ex_i (
        .clk, .reset, .advance, .flush(redirect), .decoded_in(decoded),
        .decoded_out(ex)
    );

    lc3b_execute execute_i (
        .clk, .reset, .ex, .redirect, .redirect_pc, .rf_we, .rf_dest, .rf_wdata,
        .ret_valid, .ret_pc, .ret_we, .ret_dest, .ret_value, .ret_nzp
    );

endmodule

`default_nettype wire

// ==== verification/lc3b_inst_rom_model.sv ====
`timescale 1ns/10ps
`default_nettype none

module lc3b_inst_rom_model
    import lc3b_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     random_wait,
    input  lc3b_word end_adr,
    input  logic     wb_cyc,
    input  logic     wb_stb,
    input  logic     wb_we,
    input  lc3b_word wb_adr,
    output lc3b_word wb_dat_o,
    output logic     wb_ack
);

    lc3b_word    mem [256];
    logic [31:0] lfsr;
    logic [31:0] lfsr_one;
    logic [31:0] lfsr_two;
    logic [1:0]  wait_left;
    logic        busy;
    logic        ack_q;
    logic        request;

    // 32-bit Galois LFSR, x^32 + x^22 + x^2 + x + 1, output bit is bit 0
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0])
            return (state >> 1) ^ 32'h8020_0003;
        return state >> 1;
    endfunction

    assign lfsr_one = lfsr_step(lfsr);
    assign lfsr_two = lfsr_step(lfsr_one);

    assign request = wb_cyc && wb_stb && !wb_we && wb_adr < end_adr;

    // without random waits every request is acked at once, so fetches
    // can complete back to back
    assign wb_ack   = !reset && (random_wait ? ack_q : request);
    assign wb_dat_o = wb_ack ? mem[wb_adr[8:1]] : 16'h0000;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ack_q     <= 1'b0;
            busy      <= 1'b0;
            wait_left <= 2'd0;
            lfsr      <= 32'd75979;
        end
        else if (ack_q)
        begin
            ack_q <= 1'b0;
            busy  <= 1'b0;
        end
        else if (random_wait && request)
        begin
            // two bits are drawn when a new transaction is first seen
            if (!busy)
            begin
                lfsr <= lfsr_two;
                if ({lfsr[0], lfsr_one[0]} == 2'd0)
                    ack_q <= 1'b1;
                else
                    wait_left <= {lfsr[0], lfsr_one[0]} - 2'd1;
                busy <= 1'b1;
            end
            else if (wait_left == 2'd0)
            begin
                ack_q <= 1'b1;
            end
            else
            begin
                wait_left <= wait_left - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/lc3b_core_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module lc3b_core_tb
    import lc3b_pkg::*;
();

    localparam lc3b_word start_pc     = 16'h0040;
    localparam int       beat_timeout = 200;
    localparam int       drain_cycles = 40;
    localparam logic [1:0] shf_left  = 2'b00;
    localparam logic [1:0] shf_logic = 2'b01;
    localparam logic [1:0] shf_arith = 2'b11;

    typedef struct packed
    {
        lc3b_word pc;
        logic     we;
        lc3b_reg  dest;
        lc3b_word value;
        lc3b_nzp  nzp;
    } retire_beat_t;

    logic     clk;
    logic     reset;
    logic     random_wait;
    lc3b_word end_adr;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    lc3b_word wb_adr;
    lc3b_word wb_dat;
    logic     wb_ack;
    logic     ret_valid;
    lc3b_word ret_pc;
    logic     ret_we;
    lc3b_reg  ret_dest;
    lc3b_word ret_value;
    lc3b_nzp  ret_nzp;

    lc3b_word     prog [$];
    retire_beat_t expected [$];
    int           error_count;
    int           tests_run;
    int           tests_failed;
    int           pending_redirects;

    lc3b_core #(.RESET_PC(start_pc)) lc3b_core_i (
        .clk, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_i(wb_dat), .wb_ack,
        .ret_valid, .ret_pc, .ret_we, .ret_dest, .ret_value, .ret_nzp
    );

    lc3b_inst_rom_model rom_i (
        .clk, .reset, .random_wait, .end_adr, .wb_cyc, .wb_stb, .wb_we, .wb_adr,
        .wb_dat_o(wb_dat), .wb_ack
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // counts redirects that hit a fetch still waiting for its ack
    always @(negedge clk)
    begin
        if (!reset && lc3b_core_i.redirect && wb_stb && !wb_ack)
            pending_redirects++;
    end

    function automatic lc3b_word alu_reg_instr(input lc3b_opcode op, input lc3b_reg dr,
                                               input lc3b_reg sr1, input lc3b_reg sr2);
        return {op, dr, sr1, 3'b000, sr2};
    endfunction

    function automatic lc3b_word alu_imm_instr(input lc3b_opcode op, input lc3b_reg dr,
                                               input lc3b_reg sr1, input int imm);
        return {op, dr, sr1, 1'b1, imm[4:0]};
    endfunction

    function automatic lc3b_word not_instr(input lc3b_reg dr, input lc3b_reg sr);
        return {4'b1001, dr, sr, 6'b111111};
    endfunction

    function automatic lc3b_word shift_instr(input lc3b_reg dr, input lc3b_reg sr,
                                             input logic [1:0] kind, input logic [3:0] amount);
        return {4'b1101, dr, sr, kind, amount};
    endfunction

    function automatic lc3b_word branch_instr(input lc3b_nzp mask, input int offset);
        return {4'b0000, mask, offset[8:0]};
    endfunction

    function automatic lc3b_word lea_instr(input lc3b_reg dr, input int offset);
        return {4'b1110, dr, offset[8:0]};
    endfunction

    function automatic lc3b_word jmp_instr(input lc3b_reg base);
        return {4'b1100, 3'b000, base, 6'b000000};
    endfunction

    function automatic lc3b_word jsr_instr(input int offset);
        return {4'b0100, 1'b1, offset[10:0]};
    endfunction

    function automatic lc3b_word jsrr_instr(input lc3b_reg base);
        return {4'b0100, 3'b000, base, 6'b000000};
    endfunction

    function automatic lc3b_word sign_extend(input lc3b_word field, input int bits);
        lc3b_word result;
        int       k;
        result = field;
        for (k = bits; k < 16; k++)
            result[k] = field[bits - 1];
        return result;
    endfunction

    // kind is instruction bits 5:4, bit 4 selects right and bit 5 arithmetic
    function automatic lc3b_word shift_value(input lc3b_word value, input logic [1:0] kind,
                                             input logic [3:0] amount);
        logic [31:0] wide;
        wide = {{16{value[15]}}, value} >> amount;
        if (!kind[0])
            return value << amount;
        if (!kind[1])
            return value >> amount;
        return wide[15:0];
    endfunction

    // instruction set model, walks the program in architectural order
    task automatic build_expected();
        lc3b_word     regs [8];
        lc3b_nzp      cc;
        lc3b_word     pc;
        lc3b_word     instr;
        lc3b_word     next_pc;
        lc3b_word     src_a;
        lc3b_word     src_b;
        lc3b_word     target;
        logic         write_cc;
        retire_beat_t beat;
        int           i;
        int           steps;
        expected.delete();
        for (i = 0; i < 8; i++)
            regs[i] = 16'h0000;
        cc    = 3'b010;
        pc    = start_pc;
        steps = 0;
        while (pc >= start_pc && pc < start_pc + 2 * prog.size() && steps < 1000)
        begin
            instr      = prog[(pc - start_pc) / 2];
            next_pc    = pc + 16'd2;
            src_a      = regs[instr[8:6]];
            src_b      = instr[5] ? sign_extend(instr, 5) : regs[instr[2:0]];
            write_cc   = 1'b0;
            beat.pc    = pc;
            beat.we    = 1'b0;
            beat.dest  = instr[11:9];
            beat.value = 16'h0000;
            case (instr[15:12])
                4'b0001, 4'b0101, 4'b1001, 4'b1101:
                begin
                    beat.we  = 1'b1;
                    write_cc = 1'b1;
                    if (instr[15:12] == 4'b0001)
                        beat.value = src_a + src_b;
                    else if (instr[15:12] == 4'b0101)
                        beat.value = src_a & src_b;
                    else if (instr[15:12] == 4'b1001)
                        beat.value = ~src_a;
                    else
                        beat.value = shift_value(src_a, instr[5:4], instr[3:0]);
                end
                4'b1110:
                begin
                    beat.we    = 1'b1;
                    beat.value = next_pc + (sign_extend(instr, 9) << 1);
                end
                4'b0000:
                begin
                    if (|(instr[11:9] & cc))
                        next_pc = next_pc + (sign_extend(instr, 9) << 1);
                end
                4'b1100:
                    next_pc = src_a;
                4'b0100:
                begin
                    target     = instr[11] ? next_pc + (sign_extend(instr, 11) << 1) : src_a;
                    beat.we    = 1'b1;
                    beat.dest  = 3'd7;
                    beat.value = next_pc;
                    next_pc    = target;
                end
                default:
                    beat.we = 1'b0;
            endcase
            if (write_cc)
                cc = beat.value[15] ? 3'b100 : (beat.value == 16'h0000 ? 3'b010 : 3'b001);
            if (beat.we)
                regs[beat.dest] = beat.value;
            beat.nzp = cc;
            expected.push_back(beat);
            pc = next_pc;
            steps++;
        end
    endtask

    task automatic report_mismatch(input string signal, input lc3b_word got, input lc3b_word want);
        $display("mismatch at time %0t: %s is %h, expected %h", $time, signal, got, want);
        error_count++;
    endtask

    task automatic reset_and_load(input logic use_random);
        int i;
        @(negedge clk);
        reset       = 1'b1;
        random_wait = use_random;
        end_adr     = start_pc + prog.size() * 2;
        for (i = 0; i < 256; i++)
            rom_i.mem[i] = {i[7:0] ^ 8'h3c, ~i[7:0]};
        for (i = 0; i < prog.size(); i++)
            rom_i.mem[start_pc / 2 + i] = prog[i];
        pending_redirects = 0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic run_program(input string name, input logic use_random);
        retire_beat_t want;
        int           errors_before;
        int           waited;
        int           extra;
        int           k;
        errors_before = error_count;
        build_expected();
        reset_and_load(use_random);
        if (ret_valid !== 1'b0)
            report_mismatch("ret_valid", ret_valid, 16'h0000);
        waited = 0;
        while (wb_stb !== 1'b1 && waited < beat_timeout)
        begin
            @(negedge clk);
            waited++;
        end
        if (wb_stb !== 1'b1)
        begin
            $display("%s: no instruction fetch was started after reset", name);
            error_count++;
        end
        else
        begin
            if (wb_adr !== start_pc)
                report_mismatch("wb_adr", wb_adr, start_pc);
            if (wb_we !== 1'b0)
                report_mismatch("wb_we", wb_we, 16'h0000);
            if (wb_cyc !== 1'b1)
                report_mismatch("wb_cyc", wb_cyc, 16'h0001);
        end
        for (k = 0; k < expected.size(); k++)
        begin
            want   = expected[k];
            waited = 0;
            @(negedge clk);
            while (ret_valid !== 1'b1 && waited < beat_timeout)
            begin
                @(negedge clk);
                waited++;
            end
            if (ret_valid !== 1'b1)
            begin
                $display("%s: retire %0d of %0d (pc %h) never arrived", name, k + 1,
                         expected.size(), want.pc);
                error_count++;
                break;
            end
            if (ret_pc !== want.pc)
                report_mismatch("ret_pc", ret_pc, want.pc);
            if (ret_we !== want.we)
                report_mismatch("ret_we", ret_we, want.we);
            if (want.we && ret_dest !== want.dest)
                report_mismatch("ret_dest", ret_dest, want.dest);
            if (want.we && ret_value !== want.value)
                report_mismatch("ret_value", ret_value, want.value);
            if (ret_nzp !== want.nzp)
                report_mismatch("ret_nzp", ret_nzp, want.nzp);
        end
        extra = 0;
        repeat (drain_cycles)
        begin
            @(negedge clk);
            if (ret_valid === 1'b1)
                extra++;
        end
        if (extra != 0)
        begin
            $display("%s: %0d instructions retired beyond the expected end", name, extra);
            error_count++;
        end
        if (use_random && pending_redirects == 0)
        begin
            $display("%s: no redirect arrived while a fetch was pending", name);
            error_count++;
        end
        tests_run++;
        if (error_count == errors_before)
        begin
            $display("%s: passed, %0d retires checked", name, expected.size());
        end
        else
        begin
            $display("%s: failed with %0d errors", name, error_count - errors_before);
            tests_failed++;
        end
    endtask

    // two never-taken branches keep the last fetches away from the program end
    task automatic append_padding();
        prog.push_back(16'h0000);
        prog.push_back(16'h0000);
    endtask

    task automatic test_reset_fetch();
        prog.delete();
        prog.push_back(alu_imm_instr(op_add, 3'd1, 3'd0, 3));
        prog.push_back(not_instr(3'd2, 3'd1));
        append_padding();
        run_program("reset and first fetch", 1'b0);
    endtask

    task automatic test_alu();
        prog.delete();
        prog.push_back(alu_imm_instr(op_add, 3'd1, 3'd0, 7));
        prog.push_back(alu_imm_instr(op_add, 3'd2, 3'd0, -9));
        prog.push_back(alu_reg_instr(op_add, 3'd3, 3'd1, 3'd2));
        prog.push_back(alu_imm_instr(op_and, 3'd4, 3'd3, -4));
        prog.push_back(alu_reg_instr(op_and, 3'd5, 3'd1, 3'd2));
        prog.push_back(not_instr(3'd6, 3'd2));
        prog.push_back(alu_imm_instr(op_and, 3'd0, 3'd1, 0));
        prog.push_back(shift_instr(3'd1, 3'd2, shf_left, 4'd3));
        prog.push_back(shift_instr(3'd4, 3'd2, shf_logic, 4'd4));
        prog.push_back(shift_instr(3'd5, 3'd2, shf_arith, 4'd2));
        prog.push_back(shift_instr(3'd6, 3'd1, shf_arith, 4'd15));
        prog.push_back(alu_imm_instr(op_add, 3'd7, 3'd3, 2));
        prog.push_back(not_instr(3'd7, 3'd7));
        append_padding();
        run_program("alu and shifts", 1'b0);
    endtask

    task automatic test_forwarding();
        prog.delete();
        prog.push_back(alu_imm_instr(op_add, 3'd1, 3'd0, 1));
        prog.push_back(alu_reg_instr(op_add, 3'd1, 3'd1, 3'd1));
        prog.push_back(alu_reg_instr(op_add, 3'd1, 3'd1, 3'd1));
        prog.push_back(alu_imm_instr(op_add, 3'd2, 3'd1, -5));
        prog.push_back(alu_reg_instr(op_and, 3'd3, 3'd2, 3'd1));
        prog.push_back(not_instr(3'd3, 3'd3));
        prog.push_back(alu_reg_instr(op_add, 3'd4, 3'd3, 3'd2));
        prog.push_back(shift_instr(3'd4, 3'd4, shf_left, 4'd2));
        prog.push_back(shift_instr(3'd5, 3'd4, shf_arith, 4'd1));
        prog.push_back(alu_reg_instr(op_add, 3'd5, 3'd5, 3'd5));
        append_padding();
        run_program("dependent chain", 1'b0);
    endtask

    task automatic load_branch_program();
        prog.delete();
        prog.push_back(alu_imm_instr(op_add, 3'd1, 3'd0, 2));
        prog.push_back(branch_instr(3'b001, 1));
        prog.push_back(alu_imm_instr(op_add, 3'd6, 3'd0, 15));
        prog.push_back(branch_instr(3'b100, 1));
        // countdown loop, taken while positive
        prog.push_back(alu_imm_instr(op_add, 3'd1, 3'd1, -1));
        prog.push_back(branch_instr(3'b001, -2));
        prog.push_back(branch_instr(3'b010, 1));
        prog.push_back(alu_imm_instr(op_add, 3'd6, 3'd0, -1));
        prog.push_back(alu_imm_instr(op_add, 3'd2, 3'd0, -3));
        prog.push_back(branch_instr(3'b011, 1));
        prog.push_back(branch_instr(3'b100, 1));
        prog.push_back(alu_imm_instr(op_add, 3'd6, 3'd0, 1));
        prog.push_back(branch_instr(3'b111, 1));
        prog.push_back(not_instr(3'd6, 3'd6));
        prog.push_back(alu_reg_instr(op_add, 3'd3, 3'd2, 3'd2));
        prog.push_back(branch_instr(3'b000, 1));
        append_padding();
    endtask

    task automatic test_branches();
        load_branch_program();
        run_program("branches", 1'b0);
    endtask

    task automatic test_jumps();
        prog.delete();
        prog.push_back(lea_instr(3'd1, 3));
        prog.push_back(jsr_instr(4));
        prog.push_back(jsrr_instr(3'd1));
        prog.push_back(alu_imm_instr(op_add, 3'd6, 3'd0, 1));
        prog.push_back(lea_instr(3'd4, 4));
        prog.push_back(jmp_instr(3'd4));
        prog.push_back(alu_imm_instr(op_add, 3'd2, 3'd0, 5));
        prog.push_back(jmp_instr(3'd7));
        prog.push_back(alu_imm_instr(op_add, 3'd6, 3'd0, 2));
        prog.push_back(alu_imm_instr(op_add, 3'd5, 3'd7, 0));
        append_padding();
        run_program("jumps, links and lea", 1'b0);
    endtask

    task automatic test_branches_random_wait();
        load_branch_program();
        run_program("branches with random wait states", 1'b1);
    endtask

    initial
    begin
        reset             = 1'b1;
        random_wait       = 1'b0;
        end_adr           = 16'h0000;
        error_count       = 0;
        tests_run         = 0;
        tests_failed      = 0;
        pending_redirects = 0;
        test_reset_fetch();
        test_alu();
        test_forwarding();
        test_branches();
        test_jumps();
        test_branches_random_wait();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
        if (error_count == 0)
        begin
            $display("*** TEST PASSED ***");
        end
        else
        begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
src/lc3b_pkg.sv
src/lc3b_fetch.sv
src/lc3b_regfile.sv
src/lc3b_decode.sv
src/lc3b_id_ex.sv
src/lc3b_execute.sv
src/lc3b_core.sv
verification/lc3b_inst_rom_model.sv
verification/lc3b_core_tb.sv
